//--- project.f
+incdir+tb
rtl/dwu_pkg.sv
rtl/dwu_aw_planner.sv
rtl/dwu_w_packer.sv
rtl/dwu_err_responder.sv
rtl/dwu_top.sv
tb/tb_dwu.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_dwu -o sim_dwu

out=$(./obj_dir/sim_dwu)
echo "$out"

if echo "$out" | grep -qxF "all tests passed"; then
  exit 0
fi
exit 1

//--- tb/tb_dwu_tests.svh
// ####################
// Directed tests for the write upsizer
// Each drives one or two bursts and checks them
// ####################

  // Narrow beats with a byte pattern that changes per beat
  task automatic fill_beats(input int n, input logic [31:0] base, input logic [3:0] strb);
    nd_q.delete();
    ns_q.delete();
    for (int i = 0; i < n; i++) begin
      nd_q.push_back(base + 32'h10101010 * i);
      ns_q.push_back(strb);
    end
  endtask

  // Four word beats from offset 4 fill three wide words
  task automatic test_upsize_incr();
    $display("Test: upsized INCR burst");
    fill_beats(4, 32'hA3A2A1A0, 4'hF);
    run_burst(4'h3, 32'h0000_1004, 8'd3, 3'd2, 2'b01, 4'b0010, dwu_pkg::MODE_UPSIZE);
  endtask

  task automatic test_pass_incr();
    $display("Test: non-modifiable INCR burst");
    fill_beats(3, 32'hB3B2B1B0, 4'hF);
    run_burst(4'h6, 32'h0000_2000, 8'd2, 3'd2, 2'b01, 4'b0000, dwu_pkg::MODE_PASS);
  endtask

  // Halfword beats at offset 6 stay on wide lanes 6 and 7
  task automatic test_fixed_burst();
    $display("Test: FIXED burst");
    fill_beats(3, 32'hC3C2C1C0, 4'b1100);
    run_burst(4'hA, 32'h0000_3006, 8'd2, 3'd1, 2'b00, 4'b0010, dwu_pkg::MODE_PASS);
  endtask

  task automatic test_wrap_bursts();
    $display("Test: WRAP bursts");
    fill_beats(4, 32'hD3D2D1D0, 4'hF);
    run_burst(4'h5, 32'h0000_4000, 8'd3, 3'd2, 2'b10, 4'b0010, dwu_pkg::MODE_ERROR);
    // A single beat WRAP is legal and goes through
    fill_beats(1, 32'hE3E2E1E0, 4'hF);
    run_burst(4'h7, 32'h0000_4008, 8'd0, 3'd2, 2'b10, 4'b0010, dwu_pkg::MODE_PASS);
  endtask

  task automatic test_backpressure();
    $display("Test: random back-pressure");
    stall_en = 1'b1;
    fill_beats(4, 32'hA3A2A1A0, 4'hF);
    run_burst(4'h9, 32'h0000_1004, 8'd3, 3'd2, 2'b01, 4'b0010, dwu_pkg::MODE_UPSIZE);
    stall_en = 1'b0;
  endtask

//--- tb/tb_dwu.sv
// ####################
// Testbench for the AXI write upsizer
// Narrow master driver, wide slave model,
// expected-beat model, checks and timeout
// ####################

`timescale 1ns/1ps

module tb_dwu;

  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned WideDataWidth   = 64;
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned IdWidth         = 4;
  // Six bursts of at most four beats, even with heavy stalls, end far below this
  localparam int unsigned MaxCycles       = 2000;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         n_aw_valid_i;
  logic                         n_aw_ready_o;
  logic [IdWidth-1:0]           n_aw_id_i;
  logic [AddrWidth-1:0]         n_aw_addr_i;
  logic [7:0]                   n_aw_len_i;
  logic [2:0]                   n_aw_size_i;
  logic [1:0]                   n_aw_burst_i;
  logic [3:0]                   n_aw_cache_i;
  logic                         n_w_valid_i;
  logic                         n_w_ready_o;
  logic [NarrowDataWidth-1:0]   n_w_data_i;
  logic [NarrowDataWidth/8-1:0] n_w_strb_i;
  logic                         n_w_last_i;
  logic                         n_b_valid_o;
  logic                         n_b_ready_i;
  logic [IdWidth-1:0]           n_b_id_o;
  logic [1:0]                   n_b_resp_o;
  logic                         w_aw_valid_o;
  logic                         w_aw_ready_i;
  logic [IdWidth-1:0]           w_aw_id_o;
  logic [AddrWidth-1:0]         w_aw_addr_o;
  logic [7:0]                   w_aw_len_o;
  logic [2:0]                   w_aw_size_o;
  logic [1:0]                   w_aw_burst_o;
  logic [3:0]                   w_aw_cache_o;
  logic                         w_w_valid_o;
  logic                         w_w_ready_i;
  logic [WideDataWidth-1:0]     w_w_data_o;
  logic [WideDataWidth/8-1:0]   w_w_strb_o;
  logic                         w_w_last_o;
  logic                         w_b_valid_i;
  logic                         w_b_ready_o;
  logic [IdWidth-1:0]           w_b_id_i;
  logic [1:0]                   w_b_resp_i;

  int  seed = 38748;
  bit  stall_en;
  int  mismatch_cnt;
  int  fail_cnt;
  int  cycle_cnt;

  // Traffic seen by the wide slave
  logic [IdWidth-1:0]         aw_id_q[$];
  logic [AddrWidth-1:0]       aw_addr_q[$];
  logic [7:0]                 aw_len_q[$];
  logic [2:0]                 aw_size_q[$];
  logic [1:0]                 aw_burst_q[$];
  logic [3:0]                 aw_cache_q[$];
  logic [WideDataWidth-1:0]   wd_q[$];
  logic [WideDataWidth/8-1:0] ws_q[$];
  logic                       wl_q[$];
  logic [IdWidth-1:0]         b_pend_q[$];

  // Narrow stimulus and the wide beats it should turn into
  logic [NarrowDataWidth-1:0]   nd_q[$];
  logic [NarrowDataWidth/8-1:0] ns_q[$];
  logic [WideDataWidth-1:0]     exp_data_q[$];
  logic [WideDataWidth/8-1:0]   exp_strb_q[$];
  logic                         exp_last_q[$];
  int                           exp_len;
  int                           exp_size;

  dwu_top #(
    .NarrowDataWidth (NarrowDataWidth),
    .WideDataWidth   (WideDataWidth),
    .AddrWidth       (AddrWidth),
    .IdWidth         (IdWidth)
  ) u_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Wide AW and W ready plus narrow B ready, which also gates the wide B
  always @(posedge clk_i) begin : ready_gen
    if (stall_en) begin
      w_aw_ready_i <= 1'($random(seed));
      w_w_ready_i  <= 1'($random(seed));
      n_b_ready_i  <= 1'($random(seed));
    end else begin
      w_aw_ready_i <= 1'b1;
      w_w_ready_i  <= 1'b1;
      n_b_ready_i  <= 1'b1;
    end
  end

  // Wide slave records AW and W and answers OKAY with the AW id
  always @(posedge clk_i) begin : wide_slave
    if (rst_ni) begin
      if (w_aw_valid_o && w_aw_ready_i) begin
        aw_id_q.push_back(w_aw_id_o);
        aw_addr_q.push_back(w_aw_addr_o);
        aw_len_q.push_back(w_aw_len_o);
        aw_size_q.push_back(w_aw_size_o);
        aw_burst_q.push_back(w_aw_burst_o);
        aw_cache_q.push_back(w_aw_cache_o);
      end
      if (w_w_valid_o && w_w_ready_i) begin
        wd_q.push_back(w_w_data_o);
        ws_q.push_back(w_w_strb_o);
        wl_q.push_back(w_w_last_o);
        if (w_w_last_o) begin
          b_pend_q.push_back(aw_id_q[$]);
        end
      end
      if (w_b_valid_i && w_b_ready_o) begin
        void'(b_pend_q.pop_front());
      end
      w_b_valid_i <= (b_pend_q.size() > 0);
      if (b_pend_q.size() > 0) begin
        w_b_id_i <= b_pend_q[0];
      end
    end
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      fail_cnt++;
    end
  endtask

  function automatic logic [63:0] strb_mask(input logic [7:0] strb);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  task automatic clear_records();
    aw_id_q.delete();
    aw_addr_q.delete();
    aw_len_q.delete();
    aw_size_q.delete();
    aw_burst_q.delete();
    aw_cache_q.delete();
    wd_q.delete();
    ws_q.delete();
    wl_q.delete();
  endtask

  // Byte k of a beat lands on wide lane (aligned beat address mod 8) + k
  task automatic model_wide_beats(input logic [31:0] addr, input int size, input int len,
                                  input logic [1:0] burst, input bit upsize);
    int          nbytes;
    int          first_word;
    int          last_word;
    int          idx;
    int          off;
    logic [31:0] beat;
    logic [63:0] data;
    logic [7:0]  strb;
    exp_data_q.delete();
    exp_strb_q.delete();
    exp_last_q.delete();
    nbytes     = 1 << size;
    first_word = int'(addr >> 3);
    last_word  = first_word;
    for (int i = 0; i <= len; i++) begin
      beat = (addr / nbytes) * nbytes;
      if (burst != 2'b00) begin
        beat = beat + i * nbytes;
      end
      off       = int'(beat % 8);
      last_word = int'(beat >> 3);
      idx       = upsize ? last_word - first_word : i;
      while (exp_data_q.size() <= idx) begin
        exp_data_q.push_back('0);
        exp_strb_q.push_back('0);
        exp_last_q.push_back(1'b0);
      end
      data = exp_data_q[idx];
      strb = exp_strb_q[idx];
      for (int k = 0; k < nbytes; k++) begin
        data[8*(off+k) +: 8] = nd_q[i][8*(off%4+k) +: 8];
        strb[off+k]          = ns_q[i][off%4+k];
      end
      exp_data_q[idx] = data;
      exp_strb_q[idx] = strb;
    end
    exp_last_q[exp_last_q.size()-1] = 1'b1;
    // Wide length spans the words from aligned start to aligned end
    exp_len  = upsize ? last_word - first_word : len;
    exp_size = upsize ? 3 : size;
  endtask

  task automatic send_aw(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                         input logic [2:0] size, input logic [1:0] burst,
                         input logic [3:0] cache);
    n_aw_valid_i <= 1'b1;
    n_aw_id_i    <= id;
    n_aw_addr_i  <= addr;
    n_aw_len_i   <= len;
    n_aw_size_i  <= size;
    n_aw_burst_i <= burst;
    n_aw_cache_i <= cache;
    do begin
      @(posedge clk_i);
    end while (!n_aw_ready_o);
    n_aw_valid_i <= 1'b0;
  endtask

  task automatic send_w_burst();
    for (int i = 0; i < nd_q.size(); i++) begin
      n_w_valid_i <= 1'b1;
      n_w_data_i  <= nd_q[i];
      n_w_strb_i  <= ns_q[i];
      n_w_last_i  <= (i == nd_q.size() - 1);
      do begin
        @(posedge clk_i);
      end while (!n_w_ready_o);
    end
    n_w_valid_i <= 1'b0;
    n_w_last_i  <= 1'b0;
  endtask

  task automatic wait_b(input logic [3:0] id, input logic [1:0] resp);
    do begin
      @(posedge clk_i);
    end while (!(n_b_valid_o && n_b_ready_i));
    check_val("n_b_id_o", 64'(n_b_id_o), 64'(id));
    check_val("n_b_resp_o", 64'(n_b_resp_o), 64'(resp));
  endtask

  task automatic check_wide(input logic [3:0] id, input logic [31:0] addr,
                            input logic [1:0] burst, input logic [3:0] cache);
    check_true(aw_id_q.size() == 1, "wide side did not see exactly one AW");
    if (aw_id_q.size() == 1) begin
      check_val("w_aw_id_o", 64'(aw_id_q[0]), 64'(id));
      check_val("w_aw_addr_o", 64'(aw_addr_q[0]), 64'(addr));
      check_val("w_aw_len_o", 64'(aw_len_q[0]), 64'(exp_len));
      check_val("w_aw_size_o", 64'(aw_size_q[0]), 64'(exp_size));
      check_val("w_aw_burst_o", 64'(aw_burst_q[0]), 64'(burst));
      check_val("w_aw_cache_o", 64'(aw_cache_q[0]), 64'(cache));
    end
    check_val("wide W beat count", 64'(wd_q.size()), 64'(exp_data_q.size()));
    for (int i = 0; i < wd_q.size() && i < exp_data_q.size(); i++) begin
      check_val("w_w_strb_o", 64'(ws_q[i]), 64'(exp_strb_q[i]));
      check_val("w_w_data_o", wd_q[i] & strb_mask(exp_strb_q[i]),
                exp_data_q[i] & strb_mask(exp_strb_q[i]));
      check_val("w_w_last_o", 64'(wl_q[i]), 64'(exp_last_q[i]));
    end
  endtask

  task automatic run_burst(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                           input logic [2:0] size, input logic [1:0] burst,
                           input logic [3:0] cache, input dwu_pkg::mode_e mode);
    clear_records();
    model_wide_beats(addr, int'(size), int'(len), burst, mode == dwu_pkg::MODE_UPSIZE);
    send_aw(id, addr, len, size, burst, cache);
    send_w_burst();
    if (mode == dwu_pkg::MODE_ERROR) begin
      wait_b(id, 2'(dwu_pkg::RESP_SLVERR));
      check_true(aw_id_q.size() == 0, "error burst produced a wide AW");
      check_true(wd_q.size() == 0, "error burst produced wide W beats");
    end else begin
      wait_b(id, 2'(dwu_pkg::RESP_OKAY));
      check_wide(id, addr, burst, cache);
    end
  endtask

  `include "tb_dwu_tests.svh"

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    rst_ni       = 1'b0;
    stall_en     = 1'b0;
    n_aw_valid_i = 1'b0;
    n_aw_id_i    = '0;
    n_aw_addr_i  = '0;
    n_aw_len_i   = '0;
    n_aw_size_i  = '0;
    n_aw_burst_i = '0;
    n_aw_cache_i = '0;
    n_w_valid_i  = 1'b0;
    n_w_data_i   = '0;
    n_w_strb_i   = '0;
    n_w_last_i   = 1'b0;
    n_b_ready_i  = 1'b1;
    w_aw_ready_i = 1'b1;
    w_w_ready_i  = 1'b1;
    w_b_valid_i  = 1'b0;
    w_b_id_i     = '0;
    w_b_resp_i   = 2'b00;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_val("n_aw_ready_o", 64'(n_aw_ready_o), 64'd1);
    check_val("w_aw_valid_o", 64'(w_aw_valid_o), 64'd0);
    check_val("w_w_valid_o", 64'(w_w_valid_o), 64'd0);
    check_val("n_b_valid_o", 64'(n_b_valid_o), 64'd0);
    test_upsize_incr();
    test_pass_incr();
    test_fixed_burst();
    test_wrap_bursts();
    test_backpressure();
    repeat (5) @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- rtl/dwu_top.sv
// ####################
// AXI write upsizer
// 32-bit narrow master to 64-bit wide slave
// ####################

`timescale 1ns/1ps

module dwu_top #(
  parameter int unsigned NarrowDataWidth = 32,
  parameter int unsigned WideDataWidth   = 64,
  parameter int unsigned AddrWidth       = 32,
  parameter int unsigned IdWidth         = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Narrow side
  input  logic                         n_aw_valid_i,
  output logic                         n_aw_ready_o,
  input  logic [IdWidth-1:0]           n_aw_id_i,
  input  logic [AddrWidth-1:0]         n_aw_addr_i,
  input  dwu_pkg::len_t                n_aw_len_i,
  input  dwu_pkg::size_t               n_aw_size_i,
  input  logic [1:0]                   n_aw_burst_i,
  input  logic [3:0]                   n_aw_cache_i,
  input  logic                         n_w_valid_i,
  output logic                         n_w_ready_o,
  input  logic [NarrowDataWidth-1:0]   n_w_data_i,
  input  logic [NarrowDataWidth/8-1:0] n_w_strb_i,
  input  logic                         n_w_last_i,
  output logic                         n_b_valid_o,
  input  logic                         n_b_ready_i,
  output logic [IdWidth-1:0]           n_b_id_o,
  output logic [1:0]                   n_b_resp_o,
  // Wide side
  output logic                         w_aw_valid_o,
  input  logic                         w_aw_ready_i,
  output logic [IdWidth-1:0]           w_aw_id_o,
  output logic [AddrWidth-1:0]         w_aw_addr_o,
  output dwu_pkg::len_t                w_aw_len_o,
  output dwu_pkg::size_t               w_aw_size_o,
  output logic [1:0]                   w_aw_burst_o,
  output logic [3:0]                   w_aw_cache_o,
  output logic                         w_w_valid_o,
  input  logic                         w_w_ready_i,
  output logic [WideDataWidth-1:0]     w_w_data_o,
  output logic [WideDataWidth/8-1:0]   w_w_strb_o,
  output logic                         w_w_last_o,
  input  logic                         w_b_valid_i,
  output logic                         w_b_ready_o,
  input  logic [IdWidth-1:0]           w_b_id_i,
  input  logic [1:0]                   w_b_resp_i
);

  logic                       desc_valid;
  logic                       desc_ready;
  logic [AddrWidth-1:0]       desc_addr;
  dwu_pkg::size_t             desc_size;
  dwu_pkg::len_t              desc_len;
  dwu_pkg::burst_e            desc_burst;
  dwu_pkg::mode_e             desc_mode;
  logic [IdWidth-1:0]         err_id;
  logic                       pk_valid;
  logic                       pk_ready;
  logic [WideDataWidth-1:0]   pk_data;
  logic [WideDataWidth/8-1:0] pk_strb;
  logic                       pk_last;
  logic                       pk_err;

  dwu_aw_planner #(
    .WideDataWidth (WideDataWidth),
    .AddrWidth     (AddrWidth),
    .IdWidth       (IdWidth)
  ) u_planner (
    .desc_valid_o (desc_valid),
    .desc_ready_i (desc_ready),
    .desc_addr_o  (desc_addr),
    .desc_size_o  (desc_size),
    .desc_len_o   (desc_len),
    .desc_burst_o (desc_burst),
    .desc_mode_o  (desc_mode),
    .err_id_o     (err_id),
    .*
  );

  dwu_w_packer #(
    .NarrowDataWidth (NarrowDataWidth),
    .WideDataWidth   (WideDataWidth),
    .AddrWidth       (AddrWidth)
  ) u_packer (
    .desc_valid_i (desc_valid),
    .desc_ready_o (desc_ready),
    .desc_addr_i  (desc_addr),
    .desc_size_i  (desc_size),
    .desc_len_i   (desc_len),
    .desc_burst_i (desc_burst),
    .desc_mode_i  (desc_mode),
    .pk_valid_o   (pk_valid),
    .pk_ready_i   (pk_ready),
    .pk_data_o    (pk_data),
    .pk_strb_o    (pk_strb),
    .pk_last_o    (pk_last),
    .pk_err_o     (pk_err),
    .*
  );

  dwu_err_responder #(
    .WideDataWidth (WideDataWidth),
    .IdWidth       (IdWidth)
  ) u_err_resp (
    .pk_valid_i (pk_valid),
    .pk_ready_o (pk_ready),
    .pk_data_i  (pk_data),
    .pk_strb_i  (pk_strb),
    .pk_last_i  (pk_last),
    .pk_err_i   (pk_err),
    .err_id_i   (err_id),
    .*
  );

endmodule

//--- rtl/dwu_err_responder.sv
// ####################
// Error responder
// Forwards or sinks packed W beats and
// merges local SLVERR with downstream B
// ####################

`timescale 1ns/1ps

module dwu_err_responder #(
  parameter int unsigned WideDataWidth = 64,
  parameter int unsigned IdWidth       = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       pk_valid_i,
  output logic                       pk_ready_o,
  input  logic [WideDataWidth-1:0]   pk_data_i,
  input  logic [WideDataWidth/8-1:0] pk_strb_i,
  input  logic                       pk_last_i,
  input  logic                       pk_err_i,
  output logic                       w_w_valid_o,
  input  logic                       w_w_ready_i,
  output logic [WideDataWidth-1:0]   w_w_data_o,
  output logic [WideDataWidth/8-1:0] w_w_strb_o,
  output logic                       w_w_last_o,
  input  logic                       w_b_valid_i,
  output logic                       w_b_ready_o,
  input  logic [IdWidth-1:0]         w_b_id_i,
  input  logic [1:0]                 w_b_resp_i,
  output logic                       n_b_valid_o,
  input  logic                       n_b_ready_i,
  output logic [IdWidth-1:0]         n_b_id_o,
  output logic [1:0]                 n_b_resp_o,
  input  logic [IdWidth-1:0]         err_id_i
);

  logic               err_b_q;
  logic [IdWidth-1:0] err_id_q;
  logic               err_last_fire;

  assign w_w_valid_o = pk_valid_i && !pk_err_i;
  assign w_w_data_o  = pk_data_i;
  assign w_w_strb_o  = pk_strb_i;
  assign w_w_last_o  = pk_last_i;

  // Error beats are sunk; a final one waits while a SLVERR is still pending
  assign pk_ready_o    = pk_err_i ? !(pk_last_i && err_b_q) : w_w_ready_i;
  assign err_last_fire = pk_valid_i && pk_err_i && pk_last_i && !err_b_q;

  // Downstream B wins over the local response
  assign w_b_ready_o = n_b_ready_i;
  assign n_b_valid_o = w_b_valid_i || err_b_q;
  assign n_b_id_o    = w_b_valid_i ? w_b_id_i : err_id_q;
  assign n_b_resp_o  = w_b_valid_i ? w_b_resp_i : 2'(dwu_pkg::RESP_SLVERR);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_b_q <= 1'b0;
    end else if (err_last_fire) begin
      err_b_q <= 1'b1;
    end else if (!w_b_valid_i && n_b_ready_i) begin
      err_b_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_last_fire) begin
      err_id_q <= err_id_i;
    end
  end

endmodule

//--- rtl/dwu_w_packer.sv
// ####################
// W packer
// Steers narrow beats onto wide byte lanes
// and emits full or single wide beats
// ####################

`timescale 1ns/1ps

module dwu_w_packer #(
  parameter int unsigned NarrowDataWidth = 32,
  parameter int unsigned WideDataWidth   = 64,
  parameter int unsigned AddrWidth       = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         desc_valid_i,
  output logic                         desc_ready_o,
  input  logic [AddrWidth-1:0]         desc_addr_i,
  input  dwu_pkg::size_t               desc_size_i,
  input  dwu_pkg::len_t                desc_len_i,
  input  dwu_pkg::burst_e              desc_burst_i,
  input  dwu_pkg::mode_e               desc_mode_i,
  input  logic                         n_w_valid_i,
  output logic                         n_w_ready_o,
  input  logic [NarrowDataWidth-1:0]   n_w_data_i,
  input  logic [NarrowDataWidth/8-1:0] n_w_strb_i,
  output logic                         pk_valid_o,
  input  logic                         pk_ready_i,
  output logic [WideDataWidth-1:0]     pk_data_o,
  output logic [WideDataWidth/8-1:0]   pk_strb_o,
  output logic                         pk_last_o,
  output logic                         pk_err_o
);

  localparam int unsigned NarrowBytes = NarrowDataWidth / 8;
  localparam int unsigned WideBytes   = WideDataWidth / 8;
  localparam int unsigned WideMaxSize = $clog2(WideBytes);

  logic                   busy_q;
  logic                   take_q;
  logic                   pk_valid_q;
  logic                   last_q;
  logic                   err_q;
  logic [AddrWidth-1:0]   addr_q;
  logic [AddrWidth-1:0]   next_addr;
  dwu_pkg::len_t          cnt_q;
  dwu_pkg::size_t         size_q;
  dwu_pkg::burst_e        burst_q;
  dwu_pkg::mode_e         mode_q;
  dwu_pkg::addr_t         beat_base;
  logic [WideMaxSize-1:0] lane_off;
  logic [WideDataWidth-1:0] data_d;
  logic [WideDataWidth-1:0] data_q;
  logic [WideBytes-1:0]   strb_d;
  logic [WideBytes-1:0]   strb_q;
  logic                   desc_fire;
  logic                   n_w_fire;
  logic                   drain;
  logic                   word_done;

  assign desc_ready_o = !busy_q;
  assign desc_fire    = desc_valid_i && desc_ready_o;
  assign drain        = pk_valid_q && pk_ready_i;
  assign n_w_ready_o  = take_q && (!pk_valid_q || pk_ready_i);
  assign n_w_fire     = n_w_valid_i && n_w_ready_o;

  // First wide lane of the current beat
  assign beat_base = dwu_pkg::aligned_addr(dwu_pkg::addr_t'(addr_q), size_q);
  assign lane_off  = beat_base[WideMaxSize-1:0];
  assign next_addr = AddrWidth'(dwu_pkg::next_beat_addr(dwu_pkg::addr_t'(addr_q),
                                                        burst_q, size_q));

  // Send on every beat unless an upsized word is still filling
  assign word_done = (mode_q != dwu_pkg::MODE_UPSIZE) || (cnt_q == '0) ||
                     (next_addr[AddrWidth-1:WideMaxSize] != addr_q[AddrWidth-1:WideMaxSize]);

  always_comb begin : steer
    data_d = data_q;
    strb_d = strb_q;
    if (desc_fire || drain) begin
      data_d = '0;
      strb_d = '0;
    end
    if (n_w_fire) begin
      for (int b = 0; b < WideBytes; b++) begin
        if (b >= int'(lane_off) && b < int'(lane_off) + (1 << size_q)) begin
          data_d[8*b +: 8] = n_w_data_i[8*(b % NarrowBytes) +: 8];
          strb_d[b]        = n_w_strb_i[b % NarrowBytes];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      take_q     <= 1'b0;
      pk_valid_q <= 1'b0;
    end else begin
      if (desc_fire) begin
        busy_q <= 1'b1;
        take_q <= 1'b1;
      end
      // The beat count marks the final narrow beat
      if (n_w_fire && cnt_q == '0) begin
        take_q <= 1'b0;
      end
      if (drain && last_q) begin
        busy_q <= 1'b0;
      end
      if (n_w_fire && word_done) begin
        pk_valid_q <= 1'b1;
      end else if (drain) begin
        pk_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
    strb_q <= strb_d;
    if (desc_fire) begin
      addr_q  <= desc_addr_i;
      cnt_q   <= desc_len_i;
      size_q  <= desc_size_i;
      burst_q <= desc_burst_i;
      mode_q  <= desc_mode_i;
    end else if (n_w_fire) begin
      addr_q <= next_addr;
      cnt_q  <= cnt_q - 1'b1;
    end
    if (n_w_fire) begin
      last_q <= (cnt_q == '0);
      err_q  <= (mode_q == dwu_pkg::MODE_ERROR);
    end
  end

  assign pk_valid_o = pk_valid_q;
  assign pk_data_o  = data_q;
  assign pk_strb_o  = strb_q;
  assign pk_last_o  = last_q;
  assign pk_err_o   = err_q;

endmodule

//--- rtl/dwu_aw_planner.sv
// ####################
// AW planner
// Accepts the narrow AW, classifies the burst,
// issues the wide AW and hands a descriptor on
// ####################

`timescale 1ns/1ps

module dwu_aw_planner #(
  parameter int unsigned WideDataWidth = 64,
  parameter int unsigned AddrWidth     = 32,
  parameter int unsigned IdWidth       = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 n_aw_valid_i,
  output logic                 n_aw_ready_o,
  input  logic [IdWidth-1:0]   n_aw_id_i,
  input  logic [AddrWidth-1:0] n_aw_addr_i,
  input  dwu_pkg::len_t        n_aw_len_i,
  input  dwu_pkg::size_t       n_aw_size_i,
  input  logic [1:0]           n_aw_burst_i,
  input  logic [3:0]           n_aw_cache_i,
  output logic                 w_aw_valid_o,
  input  logic                 w_aw_ready_i,
  output logic [IdWidth-1:0]   w_aw_id_o,
  output logic [AddrWidth-1:0] w_aw_addr_o,
  output dwu_pkg::len_t        w_aw_len_o,
  output dwu_pkg::size_t       w_aw_size_o,
  output logic [1:0]           w_aw_burst_o,
  output logic [3:0]           w_aw_cache_o,
  output logic                 desc_valid_o,
  input  logic                 desc_ready_i,
  output logic [AddrWidth-1:0] desc_addr_o,
  output dwu_pkg::size_t       desc_size_o,
  output dwu_pkg::len_t        desc_len_o,
  output dwu_pkg::burst_e      desc_burst_o,
  output dwu_pkg::mode_e       desc_mode_o,
  output logic [IdWidth-1:0]   err_id_o
);

  localparam int unsigned WideBytes   = WideDataWidth / 8;
  localparam int unsigned WideMaxSize = $clog2(WideBytes);

  typedef enum logic {
    ST_IDLE,
    ST_HOLD
  } state_e;

  state_e               state_q;
  logic                 aw_pending_q;
  logic                 aw_fire;
  dwu_pkg::burst_e      aw_burst;
  dwu_pkg::mode_e       mode_d;
  dwu_pkg::mode_e       mode_q;
  dwu_pkg::len_t        wide_len_d;
  dwu_pkg::len_t        wide_len_q;
  dwu_pkg::len_t        len_q;
  dwu_pkg::size_t       size_q;
  dwu_pkg::burst_e      burst_q;
  logic [3:0]           cache_q;
  logic [IdWidth-1:0]   id_q;
  logic [AddrWidth-1:0] addr_q;

  assign aw_burst     = dwu_pkg::burst_e'(n_aw_burst_i);
  // Only one burst in flight, so wait for the packer as well
  assign n_aw_ready_o = (state_q == ST_IDLE) && desc_ready_i;
  assign aw_fire      = n_aw_valid_i && n_aw_ready_o;

  always_comb begin : classify
    dwu_pkg::addr_t start_addr;
    dwu_pkg::addr_t last_addr;
    dwu_pkg::addr_t end_addr;
    start_addr = dwu_pkg::aligned_addr(dwu_pkg::addr_t'(n_aw_addr_i),
                                       dwu_pkg::size_t'(WideMaxSize));
    // Address of the final narrow beat of an INCR burst
    last_addr  = dwu_pkg::aligned_addr(dwu_pkg::addr_t'(n_aw_addr_i), n_aw_size_i) +
                 (dwu_pkg::addr_t'(n_aw_len_i) << n_aw_size_i);
    end_addr   = dwu_pkg::aligned_addr(last_addr, dwu_pkg::size_t'(WideMaxSize));
    wide_len_d = dwu_pkg::len_t'((end_addr - start_addr) >> WideMaxSize);

    mode_d = dwu_pkg::MODE_PASS;
    if (n_aw_len_i != '0) begin
      if (aw_burst == dwu_pkg::BURST_INCR && n_aw_cache_i[1]) begin
        mode_d = dwu_pkg::MODE_UPSIZE;
      end else if (aw_burst == dwu_pkg::BURST_WRAP) begin
        mode_d = dwu_pkg::MODE_ERROR;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      aw_pending_q <= 1'b0;
      mode_q       <= dwu_pkg::MODE_PASS;
    end else if (aw_fire) begin
      state_q      <= ST_HOLD;
      // Error bursts never reach the wide side
      aw_pending_q <= (mode_d != dwu_pkg::MODE_ERROR);
      mode_q       <= mode_d;
    end else begin
      if (w_aw_valid_o && w_aw_ready_i) begin
        aw_pending_q <= 1'b0;
      end
      if (desc_valid_o && desc_ready_i) begin
        state_q <= ST_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      id_q       <= n_aw_id_i;
      addr_q     <= n_aw_addr_i;
      len_q      <= n_aw_len_i;
      size_q     <= n_aw_size_i;
      burst_q    <= aw_burst;
      cache_q    <= n_aw_cache_i;
      wide_len_q <= wide_len_d;
    end
  end

  assign w_aw_valid_o = aw_pending_q;
  assign w_aw_id_o    = id_q;
  assign w_aw_addr_o  = addr_q;
  assign w_aw_burst_o = burst_q;
  assign w_aw_cache_o = cache_q;
  assign w_aw_len_o   = (mode_q == dwu_pkg::MODE_UPSIZE) ? wide_len_q : len_q;
  assign w_aw_size_o  = (mode_q == dwu_pkg::MODE_UPSIZE) ?
                        dwu_pkg::size_t'(WideMaxSize) : size_q;

  // Descriptor follows the wide AW handshake
  assign desc_valid_o = (state_q == ST_HOLD) && !aw_pending_q;
  assign desc_addr_o  = addr_q;
  assign desc_size_o  = size_q;
  assign desc_len_o   = len_q;
  assign desc_burst_o = burst_q;
  assign desc_mode_o  = mode_q;
  assign err_id_o     = id_q;

endmodule

//--- rtl/dwu_pkg.sv
// ####################
// AXI upsizer shared types
// Burst, response and size encodings plus
// address helpers for the write path
// ####################

package dwu_pkg;

  // Address helpers work on the widest address and callers cast back
  localparam int unsigned AddrBits = 64;

  typedef logic [AddrBits-1:0] addr_t;

  // log2 of bytes per beat
  typedef logic [2:0] size_t;

  // Beats minus one
  typedef logic [7:0] len_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // How the packer treats the current burst
  typedef enum logic [1:0] {
    MODE_PASS   = 2'b00,
    MODE_UPSIZE = 2'b01,
    MODE_ERROR  = 2'b10
  } mode_e;

  // Clear the address bits below the beat size
  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    return (addr >> size) << size;
  endfunction

  // Address of the beat that follows addr in a burst
  function automatic addr_t next_beat_addr(addr_t addr, burst_e burst, size_t size);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return aligned_addr(addr, size) + (addr_t'(1) << size);
  endfunction

endpackage
